// ==== include/bp_settings.svh ====
// Sizing macros for the tagged branch predictor table and its query buffer
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Fetch and resolve address width
`define BP_PC_W 32

// Global history bits fed in from outside
`define BP_GHR_W 12

// Table index width for 64 entries
`define BP_IDX_W 6

// Partial tag stored per entry
`define BP_TAG_W 8

// Queries kept around for matching resolves
`define BP_BUF_DEPTH 8

`endif

// ==== src/bp_types_pkg.sv ====
// Vector types for the branch predictor and the fold used for index and tag hashing
`include "bp_settings.svh"

package bp_types_pkg;

    typedef logic [`BP_PC_W-1:0]  pc_t;
    typedef logic [`BP_GHR_W-1:0] ghr_t;
    typedef logic [`BP_IDX_W-1:0] pht_idx_t;
    typedef logic [`BP_TAG_W-1:0] pht_tag_t;

    // Direction counter whose top bit predicts taken
    typedef logic [2:0] ctr_t;

    // Weakly taken
    localparam ctr_t CTR_WEAK_TAKEN = 3'b100;

    // XOR of consecutive out_w wide slices starting at bit 0.
    // The top slice is zero padded, so narrower inputs are zero extended
    // before the call. Only the low out_w bits of the result are meaningful
    function automatic pc_t fold(input pc_t val, input int unsigned out_w);
        pc_t res;
        res = '0;
        for (int i = 0; i < `BP_PC_W; i++) begin
            res[i % out_w] = res[i % out_w] ^ val[i];
        end
        return res;
    endfunction

endpackage

// ==== src/bp_ctrl_pkg.sv ====
// Control encodings for the tagged predictor table
package bp_ctrl_pkg;

    // Table init sweep
    typedef enum logic {
        INIT_CLEAR,
        INIT_DONE
    } init_state_e;

endpackage

// ==== src/bp_if.sv ====
// Query and update bundles between the hasher, the in-flight buffer and the table

interface bp_query_if
    import bp_types_pkg::*;
();

    logic     query_valid;
    pc_t      query_pc;
    pht_idx_t query_idx;
    pht_tag_t query_tag;

    modport producer (
        output query_valid,
        output query_pc,
        output query_idx,
        output query_tag
    );

    // Table only needs the hashed fields
    modport lookup (
        input query_idx,
        input query_tag
    );

    modport capture (
        input query_valid,
        input query_pc,
        input query_idx,
        input query_tag
    );

endinterface

interface bp_update_if
    import bp_types_pkg::*;
();

    logic     upd_valid;
    pht_idx_t upd_idx;
    pht_tag_t upd_tag;
    logic     upd_taken;

    modport source (
        output upd_valid,
        output upd_idx,
        output upd_tag,
        output upd_taken
    );

    modport sink (
        input upd_valid,
        input upd_idx,
        input upd_tag,
        input upd_taken
    );

endinterface

// ==== src/bp_query_hash.sv ====
// Query hasher folding fetch PC and global history into table index and tag
`include "bp_settings.svh"

module bp_query_hash
    import bp_types_pkg::*;
(
    input  logic         query_valid_i,
    input  pc_t          query_pc_i,
    input  ghr_t         ghr_i,
    bp_query_if.producer qry
);

    pc_t ghr_fold;
    pc_t pc_fold;

    // History zero extended up to PC width before folding
    assign ghr_fold = fold(pc_t'(ghr_i), `BP_IDX_W);
    assign pc_fold  = fold(query_pc_i, `BP_TAG_W);

    assign qry.query_valid = query_valid_i;
    assign qry.query_pc    = query_pc_i;

    // PC bits 1:0 are always zero for aligned fetch and are skipped
    assign qry.query_idx = ghr_fold[`BP_IDX_W-1:0] ^ query_pc_i[`BP_IDX_W+1:2];

    assign qry.query_tag = pc_fold[`BP_TAG_W-1:0];

endmodule

// ==== src/bp_inflight_buffer.sv ====
// In-flight query buffer that pairs a resolving branch with the index and tag it used
`include "bp_settings.svh"

module bp_inflight_buffer
    import bp_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    bp_query_if.capture qry,
    input  logic        update_valid_i,
    input  pc_t         update_pc_i,
    input  logic        update_taken_i,
    bp_update_if.source upd
);

    localparam int DEPTH = `BP_BUF_DEPTH;

    logic [DEPTH-1:0] buf_valid;
    pc_t              buf_pc  [DEPTH];
    pht_idx_t         buf_idx [DEPTH];
    pht_tag_t         buf_tag [DEPTH];

    logic [DEPTH-1:0] pc_match;
    logic             hit;
    pht_idx_t         hit_idx;
    pht_tag_t         hit_tag;

    // Slot 0 is the youngest; an idle cycle pushes a blank slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= '0;
        end else begin
            buf_valid <= {buf_valid[DEPTH-2:0], qry.query_valid};
        end
    end

    always_ff @(posedge clk) begin
        buf_pc[0]  <= qry.query_pc;
        buf_idx[0] <= qry.query_idx;
        buf_tag[0] <= qry.query_tag;
        for (int i = 1; i < DEPTH; i++) begin
            buf_pc[i]  <= buf_pc[i-1];
            buf_idx[i] <= buf_idx[i-1];
            buf_tag[i] <= buf_tag[i-1];
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            pc_match[i] = buf_valid[i] && (buf_pc[i] == update_pc_i);
        end
    end

    // Scan oldest to youngest so the lowest matching slot wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        hit_tag = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (pc_match[i]) begin
                hit     = 1'b1;
                hit_idx = buf_idx[i];
                hit_tag = buf_tag[i];
            end
        end
    end

    // Resolves that miss the buffer are dropped here
    assign upd.upd_valid = update_valid_i && hit;
    assign upd.upd_idx   = hit_idx;
    assign upd.upd_tag   = hit_tag;
    assign upd.upd_taken = update_taken_i;

    a_upd_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        upd.upd_valid |-> !$isunknown({upd.upd_idx, upd.upd_tag, upd.upd_taken})
    ) else $error("table update carries an unknown index, tag or direction");

endmodule

// ==== src/bp_tagged_table.sv ====
// Tagged counter table with same-cycle lookup, saturating update and init sweep
`include "bp_settings.svh"

module bp_tagged_table
    import bp_types_pkg::*;
    import bp_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    bp_query_if.lookup qry,
    bp_update_if.sink  upd,
    output logic       taken_o,
    output logic       tag_hit_o,
    output logic       ready_o
);

    localparam int ENTRIES = 1 << `BP_IDX_W;

    ctr_t     ctr_mem [ENTRIES];
    pht_tag_t tag_mem [ENTRIES];

    init_state_e state;
    pht_idx_t    sweep_idx;

    logic upd_en;
    ctr_t upd_ctr;
    ctr_t upd_ctr_next;

    // Lookup sees contents as of the last edge
    assign taken_o   = ctr_mem[qry.query_idx][2];
    assign tag_hit_o = (tag_mem[qry.query_idx] == qry.query_tag);
    assign ready_o   = (state == INIT_DONE);

    // One entry cleared per cycle after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= INIT_CLEAR;
            sweep_idx <= '0;
        end else begin
            case (state)
                INIT_CLEAR: begin
                    sweep_idx <= pht_idx_t'(sweep_idx + 1'b1);
                    if (sweep_idx == pht_idx_t'(ENTRIES - 1)) begin
                        state <= INIT_DONE;
                    end
                end
                default: begin
                    state <= INIT_DONE;
                end
            endcase
        end
    end

    assign upd_en  = upd.upd_valid && ready_o;
    assign upd_ctr = ctr_mem[upd.upd_idx];

    // Saturate at 000 and 111
    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd.upd_taken) begin
            if (upd_ctr != 3'b111) begin
                upd_ctr_next = upd_ctr + 3'd1;
            end
        end else if (upd_ctr != 3'b000) begin
            upd_ctr_next = upd_ctr - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == INIT_CLEAR) begin
            ctr_mem[sweep_idx] <= CTR_WEAK_TAKEN;
            tag_mem[sweep_idx] <= '0;
        end else if (upd_en) begin
            ctr_mem[upd.upd_idx] <= upd_ctr_next;
            // On a tag miss the resolving branch takes over the entry
            if (tag_mem[upd.upd_idx] != upd.upd_tag) begin
                tag_mem[upd.upd_idx] <= upd.upd_tag;
            end
        end
    end

    a_ready_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        ready_o |=> ready_o
    ) else $error("ready dropped after init sweep");

    // A counter at its bound pushed further stays there
    a_ctr_saturates: assert property (
        @(posedge clk) disable iff (!rst_n)
        upd_en && ((upd_ctr == 3'b111 && upd.upd_taken) ||
                   (upd_ctr == 3'b000 && !upd.upd_taken))
        |=> ctr_mem[$past(upd.upd_idx)] == $past(upd_ctr)
    ) else $error("direction counter wrapped past its bound");

endmodule

// ==== src/branch_predictor_top.sv ====
// Tagged branch predictor component with query hashing, in-flight buffer and table
module branch_predictor_top
    import bp_types_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    // Fetch query
    input  logic query_valid_i,
    input  pc_t  query_pc_i,
    input  ghr_t ghr_i,

    // Branch resolve
    input  logic update_valid_i,
    input  pc_t  update_pc_i,
    input  logic update_taken_i,

    output logic taken_o,
    output logic tag_hit_o,
    output logic ready_o
);

    bp_query_if  qry_if ();
    bp_update_if upd_if ();

    bp_query_hash i_query_hash (
        .query_valid_i (query_valid_i),
        .query_pc_i    (query_pc_i),
        .ghr_i         (ghr_i),
        .qry           (qry_if)
    );

    bp_inflight_buffer i_inflight_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .qry            (qry_if),
        .update_valid_i (update_valid_i),
        .update_pc_i    (update_pc_i),
        .update_taken_i (update_taken_i),
        .upd            (upd_if)
    );

    bp_tagged_table i_tagged_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .qry       (qry_if),
        .upd       (upd_if),
        .taken_o   (taken_o),
        .tag_hit_o (tag_hit_o),
        .ready_o   (ready_o)
    );

endmodule

// ==== verification/tb_branch_predictor.sv ====
// Table-driven testbench for the tagged branch predictor against a counter and tag model
`include "bp_settings.svh"

module tb_branch_predictor
    import bp_types_pkg::*;
();

    localparam int ENTRIES = 1 << `BP_IDX_W;
    localparam int N_RANDOM = 12;

    logic clk;
    logic rst_n;
    logic query_valid_i;
    pc_t  query_pc_i;
    ghr_t ghr_i;
    logic update_valid_i;
    pc_t  update_pc_i;
    logic update_taken_i;
    logic taken_o;
    logic tag_hit_o;
    logic ready_o;

    // Stimulus table with one entry per row in each queue
    string row_name  [$];
    pc_t   row_pc    [$];
    ghr_t  row_ghr   [$];
    int    row_delay [$];
    logic  row_taken [$];
    int    num_rows;

    ctr_t     model_ctr [ENTRIES];
    pht_tag_t model_tag [ENTRIES];

    logic [15:0] lfsr;
    int errors;
    int checks;
    int rows_ok;

    branch_predictor_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .query_valid_i  (query_valid_i),
        .query_pc_i     (query_pc_i),
        .ghr_i          (ghr_i),
        .update_valid_i (update_valid_i),
        .update_pc_i    (update_pc_i),
        .update_taken_i (update_taken_i),
        .taken_o        (taken_o),
        .tag_hit_o      (tag_hit_o),
        .ready_o        (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // XOR of out_w wide slices from bit 0 with the input already zero above in_w
    function automatic logic [31:0] fold_slices(input logic [31:0] val, input int in_w,
                                                input int out_w);
        logic [31:0] res;
        logic [31:0] mask;
        res  = '0;
        mask = (32'd1 << out_w) - 32'd1;
        for (int s = 0; s < in_w; s += out_w) begin
            res = res ^ ((val >> s) & mask);
        end
        return res;
    endfunction

    // Taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] res;
        logic        fb;
        res = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            res  = {res[30:0], lfsr[0]};
        end
        return res;
    endfunction

    task automatic add_row(input string name, input pc_t pc, input ghr_t ghr,
                           input int delay, input logic taken);
        row_name.push_back(name);
        row_pc.push_back(pc);
        row_ghr.push_back(ghr);
        row_delay.push_back(delay);
        row_taken.push_back(taken);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %0h, got %0h", name, what, exp, act);
        end
    endtask

    // Query, idle for the delay, then resolve the branch
    task automatic run_row(input int r);
        logic [31:0] gfold;
        logic [31:0] tfold;
        pht_idx_t    idx;
        pht_tag_t    tag;
        int          err_before;
        err_before = errors;
        gfold = fold_slices({20'd0, row_ghr[r]}, `BP_GHR_W, `BP_IDX_W);
        tfold = fold_slices(row_pc[r], `BP_PC_W, `BP_TAG_W);
        idx   = gfold[`BP_IDX_W-1:0] ^ row_pc[r][`BP_IDX_W+1:2];
        tag   = tfold[`BP_TAG_W-1:0];
        @(negedge clk);
        update_valid_i = 1'b0;
        query_valid_i  = 1'b1;
        query_pc_i     = row_pc[r];
        ghr_i          = row_ghr[r];
        #1;
        check_value(row_name[r], "taken", model_ctr[idx][2], taken_o);
        check_value(row_name[r], "tag_hit", model_tag[idx] == tag, tag_hit_o);
        check_value(row_name[r], "ready", 1'b1, ready_o);
        repeat (row_delay[r]) begin
            @(negedge clk);
            query_valid_i = 1'b0;
        end
        @(negedge clk);
        query_valid_i  = 1'b0;
        update_valid_i = 1'b1;
        update_pc_i    = row_pc[r];
        update_taken_i = row_taken[r];
        // Query has left the buffer once the delay reaches its depth
        if (row_delay[r] < `BP_BUF_DEPTH) begin
            if (row_taken[r] && model_ctr[idx] != 3'b111) begin
                model_ctr[idx] = model_ctr[idx] + 3'd1;
            end else if (!row_taken[r] && model_ctr[idx] != 3'b000) begin
                model_ctr[idx] = model_ctr[idx] - 3'd1;
            end
            model_tag[idx] = tag;
        end
        if (errors == err_before) begin
            rows_ok++;
            $display("[ok]   %s", row_name[r]);
        end else begin
            $display("[bad]  %s", row_name[r]);
        end
    endtask

    task automatic build_table();
        add_row("fresh_tag_zero", 32'h0101_0000, 12'h000, 8, 1'b0);
        add_row("fresh_other", 32'h0040_2000, 12'h155, 9, 1'b0);
        for (int k = 1; k <= 5; k++) begin
            add_row($sformatf("not_taken_%0d", k), 32'h0000_1234, 12'h0A5, 0, 1'b0);
        end
        for (int k = 1; k <= 4; k++) begin
            add_row($sformatf("taken_%0d", k), 32'h0000_1234, 12'h0A5, 1, 1'b1);
        end
        add_row("taken_again", 32'h0000_1234, 12'h0A5, 9, 1'b0);
        add_row("tag_new", 32'h0000_5678, 12'h3C3, 3, 1'b1);
        add_row("tag_stored", 32'h0000_5678, 12'h3C3, 9, 1'b1);
        // Same index with tags 40 and 41
        add_row("alias_a", 32'h0000_0040, 12'h2F0, 0, 1'b1);
        add_row("alias_b", 32'h0000_0140, 12'h2F0, 0, 1'b0);
        add_row("alias_a_again", 32'h0000_0040, 12'h2F0, 0, 1'b1);
        add_row("alias_b_again", 32'h0000_0140, 12'h2F0, 9, 1'b1);
        add_row("late_8", 32'h0000_9ABC, 12'h111, 8, 1'b0);
        add_row("late_10", 32'h0000_9ABC, 12'h111, 10, 1'b0);
        add_row("in_time_7", 32'h0000_9ABC, 12'h111, 7, 1'b0);
        add_row("late_check", 32'h0000_9ABC, 12'h111, 9, 1'b0);
        add_row("dup_old", 32'h0000_7770, 12'h001, 0, 1'b1);
        add_row("dup_young", 32'h0000_7770, 12'h800, 0, 1'b0);
        add_row("dup_check_old", 32'h0000_7770, 12'h001, 9, 1'b0);
        add_row("dup_check_young", 32'h0000_7770, 12'h800, 9, 1'b0);
        for (int k = 0; k < N_RANDOM; k++) begin
            add_row($sformatf("rand_%0d", k), next_bits(32), ghr_t'(next_bits(12)),
                    int'(next_bits(4)) % (`BP_BUF_DEPTH + 3), next_bits(1));
        end
    endtask

    // Each row takes at most BP_BUF_DEPTH+4 cycles
    initial begin
        wait (num_rows > 0);
        repeat (num_rows * (`BP_BUF_DEPTH + 4) + ENTRIES + 16) @(posedge clk);
        $display("watchdog expired before all rows finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        int sweep_cycles;
        rst_n          = 1'b0;
        query_valid_i  = 1'b0;
        query_pc_i     = '0;
        ghr_i          = '0;
        update_valid_i = 1'b0;
        update_pc_i    = '0;
        update_taken_i = 1'b0;
        lfsr           = 16'd38108;
        errors         = 0;
        checks         = 0;
        rows_ok        = 0;
        sweep_cycles   = 0;
        build_table();
        num_rows = row_name.size();
        for (int e = 0; e < ENTRIES; e++) begin
            model_ctr[e] = 3'b100;
            model_tag[e] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        while (!ready_o && sweep_cycles < ENTRIES + 8) begin
            @(negedge clk);
            sweep_cycles++;
        end
        if (!ready_o) begin
            $display("ready_o never rose after the table init sweep");
            $display("Test failed");
            $finish;
        end else begin
            check_value("init_sweep", "cycles", ENTRIES, sweep_cycles);
            if (errors == 0) begin
                $display("[ok]   init_sweep");
            end else begin
                $display("[bad]  init_sweep");
            end
            for (int r = 0; r < num_rows; r++) begin
                run_row(r);
            end
            @(negedge clk);
            update_valid_i = 1'b0;
            $display("rows: %0d, rows ok: %0d, checks: %0d, errors: %0d",
                     num_rows, rows_ok, checks, errors);
            if (errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// ==== branch_predictor_top.f ====
+incdir+include
src/bp_types_pkg.sv
src/bp_ctrl_pkg.sv
src/bp_if.sv
src/bp_query_hash.sv
src/bp_inflight_buffer.sv
src/bp_tagged_table.sv
src/branch_predictor_top.sv
verification/tb_branch_predictor.sv
